// ==== all.f ====
design/cp0_pkg.sv
design/cp0_regs.sv
design/exc_prioritizer.sv
design/tlb_mmu.sv
design/cp0_top.sv
dv/cp0_properties.sv
dv/cp0_tb.sv

// ==== design/cp0_pkg.sv ====
`default_nettype none

package cp0_pkg;

    // CP0 register numbers used by MFC0/MTC0.
    typedef enum logic [4:0] {
        INDEX    = 5'd0,
        ENTRYLO0 = 5'd2,
        ENTRYLO1 = 5'd3,
        BADVADDR = 5'd8,
        COUNT    = 5'd9,
        ENTRYHI  = 5'd10,
        COMPARE  = 5'd11,
        STATUS   = 5'd12,
        CAUSE    = 5'd13,
        EPC      = 5'd14,
        EBASE    = 5'd15
    } cp0_reg_e;

    // Cause.ExcCode values.
    typedef enum logic [4:0] {
        INT  = 5'd0,
        MOD  = 5'd1,
        TLBL = 5'd2,
        TLBS = 5'd3,
        ADEL = 5'd4,
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        OV   = 5'd12
    } exc_code_e;

    localparam logic [31:0] STATUS_RESET = 32'h1000_0000;
    localparam logic [31:0] EBASE_RESET  = 32'h8000_0000;

    // General exception vector offset from EBase.
    localparam logic [31:0] EXC_OFFSET   = 32'h0000_0180;

endpackage

`default_nettype wire

// ==== design/cp0_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_regs #(
    parameter int TLB_ENTRIES = 16,
    localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire  [4:0]           rd_addr_i,
    output logic [31:0]          rd_data_o,
    input  wire                  we_i,
    input  wire  [4:0]           wr_addr_i,
    input  wire  [31:0]          wr_data_i,
    input  wire  [5:0]           hardware_int_i,
    input  wire                  en_exp_i,
    input  cp0_pkg::exc_code_e   exp_code_i,
    input  wire                  exp_bd_i,
    input  wire  [31:0]          exp_epc_i,
    input  wire  [31:0]          exp_bad_vaddr_i,
    input  wire                  clean_exl_i,
    output logic                 timer_int_o,
    output logic                 allow_int_o,
    output logic                 status_exl_o,
    output logic [1:0]           software_int_o,
    output logic [31:0]          epc_o,
    output logic [19:0]          ebase_o,
    output logic [18:0]          entry_hi_vpn2_o,
    output logic [25:0]          lo0_o,
    output logic [25:0]          lo1_o,
    output logic [IDX_W-1:0]     index_o
);

    logic [31:0]      count_q;
    logic [31:0]      compare_q;
    logic             timer_int_q;
    logic             status_um_q;
    logic             status_exl_q;
    logic             status_ie_q;
    logic [17:0]      ebase_q;
    logic             cause_bd_q;
    logic [1:0]       cause_ip_q;
    logic [4:0]       cause_code_q;

    logic [31:0]      epc_q;
    logic [31:0]      badvaddr_q;
    logic [18:0]      entry_hi_q;
    // EntryLo halves are kept as {PFN, D, V}.
    logic [25:0]      lo0_q;
    logic [25:0]      lo1_q;
    logic [IDX_W-1:0] index_q;

    assign timer_int_o     = timer_int_q;
    assign allow_int_o     = !status_exl_q && status_ie_q;
    assign status_exl_o    = status_exl_q;
    assign software_int_o  = cause_ip_q;
    assign epc_o           = epc_q;
    assign ebase_o         = {2'b10, ebase_q};
    assign entry_hi_vpn2_o = entry_hi_q;
    assign lo0_o           = lo0_q;
    assign lo1_o           = lo1_q;
    assign index_o         = index_q;

    always_comb begin
        case (rd_addr_i)
            cp0_pkg::INDEX:    rd_data_o = {{(32-IDX_W){1'b0}}, index_q};
            cp0_pkg::ENTRYLO0: rd_data_o = {2'b0, lo0_q[25:2], 3'b0, lo0_q[1:0], 1'b0};
            cp0_pkg::ENTRYLO1: rd_data_o = {2'b0, lo1_q[25:2], 3'b0, lo1_q[1:0], 1'b0};
            cp0_pkg::BADVADDR: rd_data_o = badvaddr_q;
            cp0_pkg::COUNT:    rd_data_o = count_q;
            cp0_pkg::ENTRYHI:  rd_data_o = {entry_hi_q, 13'b0};
            cp0_pkg::COMPARE:  rd_data_o = compare_q;
            cp0_pkg::STATUS: begin
                rd_data_o = {27'b0, status_um_q, 2'b00, status_exl_q, status_ie_q};
            end
            // Interrupt pending bits show the live hardware lines.
            cp0_pkg::CAUSE: begin
                rd_data_o = {cause_bd_q, 15'b0, hardware_int_i, cause_ip_q, 1'b0,
                             cause_code_q, 2'b00};
            end
            cp0_pkg::EPC:      rd_data_o = epc_q;
            cp0_pkg::EBASE:    rd_data_o = {2'b10, ebase_q, 12'b0};
            default:           rd_data_o = 32'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q      <= 32'b0;
            compare_q    <= 32'b0;
            timer_int_q  <= 1'b0;
            status_um_q  <= cp0_pkg::STATUS_RESET[4];
            status_exl_q <= cp0_pkg::STATUS_RESET[1];
            status_ie_q  <= cp0_pkg::STATUS_RESET[0];
            ebase_q      <= cp0_pkg::EBASE_RESET[29:12];
            cause_bd_q   <= 1'b0;
            cause_ip_q   <= 2'b0;
            cause_code_q <= 5'b0;
        end else begin
            count_q <= count_q + 32'd1;
            // A zero Compare never fires the timer.
            if (compare_q != 32'b0 && compare_q == count_q) begin
                timer_int_q <= 1'b1;
            end
            if (we_i) begin
                case (wr_addr_i)
                    cp0_pkg::COMPARE: begin
                        compare_q   <= wr_data_i;
                        timer_int_q <= 1'b0;
                    end
                    cp0_pkg::COUNT: count_q <= wr_data_i;
                    cp0_pkg::EBASE: ebase_q <= wr_data_i[29:12];
                    cp0_pkg::CAUSE: cause_ip_q <= wr_data_i[9:8];
                    cp0_pkg::STATUS: begin
                        status_um_q  <= wr_data_i[4];
                        status_exl_q <= wr_data_i[1];
                        status_ie_q  <= wr_data_i[0];
                    end
                    default: ;
                endcase
            end
            if (en_exp_i) begin
                status_exl_q <= 1'b1;
                cause_bd_q   <= exp_bd_i;
                cause_code_q <= exp_code_i;
            end
            if (clean_exl_i) begin
                status_exl_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            case (wr_addr_i)
                cp0_pkg::EPC:      epc_q <= wr_data_i;
                cp0_pkg::ENTRYHI:  entry_hi_q <= wr_data_i[31:13];
                cp0_pkg::ENTRYLO0: lo0_q <= {wr_data_i[29:6], wr_data_i[2:1]};
                cp0_pkg::ENTRYLO1: lo1_q <= {wr_data_i[29:6], wr_data_i[2:1]};
                cp0_pkg::INDEX:    index_q <= wr_data_i[IDX_W-1:0];
                default: ;
            endcase
        end
        // Exception capture wins over a same-cycle MTC0.
        if (en_exp_i) begin
            epc_q      <= exp_epc_i;
            badvaddr_q <= exp_bad_vaddr_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/cp0_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_top #(
    parameter int TLB_ENTRIES = 16,
    localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [4:0]  rd_addr_i,
    output logic [31:0] rd_data_o,
    input  wire         we_i,
    input  wire  [4:0]  wr_addr_i,
    input  wire  [31:0] wr_data_i,
    input  wire  [5:0]  hardware_int_i,
    input  wire         tlbwi_i,
    input  wire         eret_i,
    input  wire         instr_valid_i,
    input  wire  [31:0] pc_i,
    input  wire         in_delay_slot_i,
    input  wire         exc_ri_i,
    input  wire         exc_syscall_i,
    input  wire         exc_break_i,
    input  wire         exc_ov_i,
    input  wire         mem_load_i,
    input  wire         mem_store_i,
    input  wire  [31:0] mem_vaddr_i,
    output logic [31:0] mem_paddr_o,
    output logic        flush_o,
    output logic [31:0] target_pc_o,
    output logic        timer_int_o
);

    logic               status_exl;
    logic               allow_int;
    logic [1:0]         software_int;
    logic [31:0]        epc;
    logic [19:0]        ebase;
    logic [18:0]        entry_hi_vpn2;
    logic [25:0]        lo0;
    logic [25:0]        lo1;
    logic [IDX_W-1:0]   index;
    logic               en_exp;
    cp0_pkg::exc_code_e exp_code;
    logic               exp_bd;
    logic [31:0]        exp_epc;
    logic [31:0]        exp_bad_vaddr;
    logic               clean_exl;
    logic               tlb_miss;
    logic               tlb_mod;

    cp0_regs #(.TLB_ENTRIES(TLB_ENTRIES)) u_regs (
        .clk, .rst_n, .rd_addr_i, .rd_data_o, .we_i, .wr_addr_i, .wr_data_i,
        .hardware_int_i,
        .en_exp_i(en_exp), .exp_code_i(exp_code), .exp_bd_i(exp_bd),
        .exp_epc_i(exp_epc), .exp_bad_vaddr_i(exp_bad_vaddr), .clean_exl_i(clean_exl),
        .timer_int_o, .allow_int_o(allow_int), .status_exl_o(status_exl),
        .software_int_o(software_int), .epc_o(epc), .ebase_o(ebase),
        .entry_hi_vpn2_o(entry_hi_vpn2), .lo0_o(lo0), .lo1_o(lo1), .index_o(index)
    );

    exc_prioritizer u_exc (
        .instr_valid_i, .pc_i, .in_delay_slot_i, .exc_ri_i, .exc_syscall_i,
        .exc_break_i, .exc_ov_i, .eret_i, .hardware_int_i,
        .software_int_i(software_int), .timer_int_i(timer_int_o), .allow_int_i(allow_int),
        .tlb_miss_i(tlb_miss), .tlb_mod_i(tlb_mod), .mem_store_i, .mem_vaddr_i,
        .epc_i(epc), .ebase_i(ebase),
        .en_exp_o(en_exp), .exp_code_o(exp_code), .exp_bd_o(exp_bd), .exp_epc_o(exp_epc),
        .exp_bad_vaddr_o(exp_bad_vaddr), .clean_exl_o(clean_exl), .flush_o, .target_pc_o
    );

    tlb_mmu #(.TLB_ENTRIES(TLB_ENTRIES)) u_tlb (
        .clk, .rst_n, .tlbwi_i, .index_i(index), .entry_hi_vpn2_i(entry_hi_vpn2),
        .lo0_i(lo0), .lo1_i(lo1), .mem_load_i, .mem_store_i, .mem_vaddr_i,
        .mem_paddr_o, .tlb_miss_o(tlb_miss), .tlb_mod_o(tlb_mod)
    );

endmodule

`default_nettype wire

// ==== design/exc_prioritizer.sv ====
`timescale 1ns/1ps
`default_nettype none

module exc_prioritizer (
    input  wire                 instr_valid_i,
    input  wire  [31:0]         pc_i,
    input  wire                 in_delay_slot_i,
    input  wire                 exc_ri_i,
    input  wire                 exc_syscall_i,
    input  wire                 exc_break_i,
    input  wire                 exc_ov_i,
    input  wire                 eret_i,
    input  wire  [5:0]          hardware_int_i,
    input  wire  [1:0]          software_int_i,
    input  wire                 timer_int_i,
    input  wire                 allow_int_i,
    input  wire                 tlb_miss_i,
    input  wire                 tlb_mod_i,
    input  wire                 mem_store_i,
    input  wire  [31:0]         mem_vaddr_i,
    input  wire  [31:0]         epc_i,
    input  wire  [19:0]         ebase_i,
    output logic                en_exp_o,
    output cp0_pkg::exc_code_e  exp_code_o,
    output logic                exp_bd_o,
    output logic [31:0]         exp_epc_o,
    output logic [31:0]         exp_bad_vaddr_o,
    output logic                clean_exl_o,
    output logic                flush_o,
    output logic [31:0]         target_pc_o
);

    logic int_pending;
    logic fetch_adel;
    logic exc_any;

    assign int_pending = allow_int_i &&
                         ((|hardware_int_i) || (|software_int_i) || timer_int_i);

    // Instruction fetch must be word aligned.
    assign fetch_adel = pc_i[1:0] != 2'b00;

    always_comb begin
        exc_any         = 1'b1;
        exp_code_o      = cp0_pkg::INT;
        exp_bad_vaddr_o = 32'b0;
        if (int_pending) begin
            exp_code_o = cp0_pkg::INT;
        end else if (fetch_adel) begin
            exp_code_o      = cp0_pkg::ADEL;
            exp_bad_vaddr_o = pc_i;
        end else if (exc_ri_i) begin
            exp_code_o = cp0_pkg::RI;
        end else if (exc_syscall_i) begin
            exp_code_o = cp0_pkg::SYS;
        end else if (exc_break_i) begin
            exp_code_o = cp0_pkg::BP;
        end else if (exc_ov_i) begin
            exp_code_o = cp0_pkg::OV;
        end else if (tlb_mod_i) begin
            exp_code_o      = cp0_pkg::MOD;
            exp_bad_vaddr_o = mem_vaddr_i;
        end else if (tlb_miss_i) begin
            exp_code_o      = mem_store_i ? cp0_pkg::TLBS : cp0_pkg::TLBL;
            exp_bad_vaddr_o = mem_vaddr_i;
        end else begin
            exc_any = 1'b0;
        end
    end

    assign en_exp_o    = instr_valid_i && exc_any;
    assign clean_exl_o = instr_valid_i && eret_i && !exc_any;
    assign flush_o     = en_exp_o || clean_exl_o;

    // A delay-slot fault restarts at the branch.
    assign exp_bd_o  = in_delay_slot_i;
    assign exp_epc_o = in_delay_slot_i ? pc_i - 32'd4 : pc_i;

    assign target_pc_o = en_exp_o ? {ebase_i, 12'b0} + cp0_pkg::EXC_OFFSET : epc_i;

endmodule

`default_nettype wire

// ==== design/tlb_mmu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_mmu #(
    parameter int TLB_ENTRIES = 16,
    localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              tlbwi_i,
    input  wire  [IDX_W-1:0] index_i,
    input  wire  [18:0]      entry_hi_vpn2_i,
    input  wire  [25:0]      lo0_i,
    input  wire  [25:0]      lo1_i,
    input  wire              mem_load_i,
    input  wire              mem_store_i,
    input  wire  [31:0]      mem_vaddr_i,
    output logic [31:0]      mem_paddr_o,
    output logic             tlb_miss_o,
    output logic             tlb_mod_o
);

    logic [TLB_ENTRIES-1:0] entry_valid_q;
    logic [18:0]            vpn2_q [TLB_ENTRIES];
    logic [25:0]            lo0_q  [TLB_ENTRIES];
    logic [25:0]            lo1_q  [TLB_ENTRIES];

    logic        unmapped;
    logic        access;
    logic        hit;
    logic [25:0] hit_lo;
    logic        page_d;
    logic        page_v;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid_q <= '0;
        end else if (tlbwi_i) begin
            entry_valid_q[index_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlbwi_i) begin
            vpn2_q[index_i] <= entry_hi_vpn2_i;
            lo0_q[index_i]  <= lo0_i;
            lo1_q[index_i]  <= lo1_i;
        end
    end

    // kseg0 and kseg1 are direct mapped.
    assign unmapped = mem_vaddr_i[31:30] == 2'b10;
    assign access   = mem_load_i || mem_store_i;

    // Lowest matching entry wins.
    always_comb begin
        hit    = 1'b0;
        hit_lo = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (!hit && entry_valid_q[i] && vpn2_q[i] == mem_vaddr_i[31:13]) begin
                hit    = 1'b1;
                hit_lo = mem_vaddr_i[12] ? lo1_q[i] : lo0_q[i];
            end
        end
    end

    assign page_d = hit_lo[1];
    assign page_v = hit_lo[0];

    assign mem_paddr_o = unmapped ? {3'b000, mem_vaddr_i[28:0]}
                                  : {hit_lo[21:2], mem_vaddr_i[11:0]};

    assign tlb_miss_o = access && !unmapped && (!hit || !page_v);
    assign tlb_mod_o  = mem_store_i && !unmapped && hit && page_v && !page_d;

endmodule

`default_nettype wire

// ==== dv/cp0_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_properties (
    input wire        clk,
    input wire        rst_n,
    input wire        timer_int_i,
    input wire [31:0] count_i,
    input wire [31:0] compare_i,
    input wire        flush_i,
    input wire        en_exp_i,
    input wire        status_exl_i,
    input wire [17:0] ebase_q_i,
    input wire [31:0] target_pc_i
);

    int assert_errors = 0;

    // Timer sets only on the edge after Count matched a nonzero Compare.
    timer_after_match: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(timer_int_i) |-> $past(compare_i != 32'b0 && count_i == compare_i)
    ) else begin
        $error("timer interrupt rose without a Count/Compare match");
        assert_errors++;
    end

    exl_after_exception: assert property (
        @(posedge clk) disable iff (!rst_n)
        (flush_i && en_exp_i) |=> status_exl_i
    ) else begin
        $error("EXL not set the cycle after an exception flush");
        assert_errors++;
    end

    // Target is the 4 KB aligned EBase register plus the vector offset.
    exception_vector: assert property (
        @(posedge clk) disable iff (!rst_n)
        en_exp_i |-> (target_pc_i == {2'b10, ebase_q_i, 12'h180})
    ) else begin
        $error("exception target is not 0x180 above the EBase register");
        assert_errors++;
    end

endmodule

bind cp0_top cp0_properties u_props (
    .clk(clk),
    .rst_n(rst_n),
    .timer_int_i(timer_int_o),
    .count_i(u_regs.count_q),
    .compare_i(u_regs.compare_q),
    .flush_i(flush_o),
    .en_exp_i(en_exp),
    .status_exl_i(status_exl),
    .ebase_q_i(u_regs.ebase_q),
    .target_pc_i(target_pc_o)
);

`default_nettype wire

// ==== dv/cp0_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_tb;

    localparam int TLB_ENTRIES = 16;
    // The six tests take a few hundred cycles and the timer wait is the longest.
    localparam int CYCLE_LIMIT = 2000;
    localparam logic [31:0] EXC_TARGET = 32'h8000_0180;
    localparam logic [31:0] SYS_PC     = 32'h0040_0104;
    localparam logic [31:0] INT_PC     = 32'h0040_0200;
    localparam logic [31:0] MISS_VA    = 32'h0060_0010;
    localparam logic [18:0] VPN2       = 19'h00201;
    localparam logic [23:0] PFN_EVEN   = 24'h012345;
    localparam logic [23:0] PFN_ODD    = 24'h000abc;
    localparam logic [4:0]  REG_LIST [10] = '{
        cp0_pkg::INDEX, cp0_pkg::ENTRYLO0, cp0_pkg::ENTRYLO1, cp0_pkg::COUNT,
        cp0_pkg::ENTRYHI, cp0_pkg::COMPARE, cp0_pkg::STATUS, cp0_pkg::CAUSE,
        cp0_pkg::EPC, cp0_pkg::EBASE
    };

    logic        clk;
    logic        rst_n;
    logic [4:0]  rd_addr;
    logic [31:0] rd_data;
    logic        we;
    logic [4:0]  wr_addr;
    logic [31:0] wr_data;
    logic [5:0]  hardware_int;
    logic        tlbwi;
    logic        eret;
    logic        instr_valid;
    logic [31:0] pc;
    logic        in_delay_slot;
    logic        exc_ri;
    logic        exc_syscall;
    logic        exc_break;
    logic        exc_ov;
    logic        mem_load;
    logic        mem_store;
    logic [31:0] mem_vaddr;
    logic [31:0] mem_paddr;
    logic        flush;
    logic [31:0] target_pc;
    logic        timer_int;

    integer      seed;
    int          cycles = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    string       test_name;
    logic [31:0] value;
    logic [31:0] wdata;

    cp0_top #(.TLB_ENTRIES(TLB_ENTRIES)) dut0 (
        .clk(clk),
        .rst_n(rst_n),
        .rd_addr_i(rd_addr),
        .rd_data_o(rd_data),
        .we_i(we),
        .wr_addr_i(wr_addr),
        .wr_data_i(wr_data),
        .hardware_int_i(hardware_int),
        .tlbwi_i(tlbwi),
        .eret_i(eret),
        .instr_valid_i(instr_valid),
        .pc_i(pc),
        .in_delay_slot_i(in_delay_slot),
        .exc_ri_i(exc_ri),
        .exc_syscall_i(exc_syscall),
        .exc_break_i(exc_break),
        .exc_ov_i(exc_ov),
        .mem_load_i(mem_load),
        .mem_store_i(mem_store),
        .mem_vaddr_i(mem_vaddr),
        .mem_paddr_o(mem_paddr),
        .flush_o(flush),
        .target_pc_o(target_pc),
        .timer_int_o(timer_int)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not complete within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    // Readback value of a written register, from the MIPS field layout.
    function automatic logic [31:0] masked_value(input logic [4:0] addr,
                                                 input logic [31:0] data);
        case (addr)
            cp0_pkg::INDEX:    return data & 32'(TLB_ENTRIES - 1);
            cp0_pkg::ENTRYLO0,
            cp0_pkg::ENTRYLO1: return data & 32'h3fff_ffc6;
            cp0_pkg::ENTRYHI:  return data & 32'hffff_e000;
            cp0_pkg::STATUS:   return data & 32'h0000_0013;
            cp0_pkg::CAUSE:    return data & 32'h0000_0300;
            cp0_pkg::EBASE:    return (data & 32'h3fff_f000) | 32'h8000_0000;
            default:           return data;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("Test %s: pass", test_name);
            tests_passed++;
        end else begin
            $display("Test %s: fail (%0d errors)", test_name, test_errors);
            tests_failed++;
        end
    endtask

    // All tasks below start and end just after a rising edge.
    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        we <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        @(posedge clk);
        we <= 1'b0;
    endtask

    task automatic read_reg(input logic [4:0] addr, output logic [31:0] data);
        rd_addr <= addr;
        @(negedge clk);
        data = rd_data;
        @(posedge clk);
    endtask

    task automatic clear_instr();
        instr_valid <= 1'b0;
        pc <= 32'h0;
        in_delay_slot <= 1'b0;
        exc_ri <= 1'b0;
        exc_syscall <= 1'b0;
        exc_break <= 1'b0;
        exc_ov <= 1'b0;
        eret <= 1'b0;
        mem_load <= 1'b0;
        mem_store <= 1'b0;
        mem_vaddr <= 32'h0;
        hardware_int <= 6'h0;
    endtask

    task automatic issue_instr(input logic [31:0] pc_val, input logic slot,
                               input logic syscall_req, input logic eret_req,
                               input logic load_req, input logic store_req,
                               input logic [31:0] vaddr, input logic [5:0] hw_int,
                               input logic exp_flush, input logic [31:0] exp_target);
        instr_valid <= 1'b1;
        pc <= pc_val;
        in_delay_slot <= slot;
        exc_syscall <= syscall_req;
        eret <= eret_req;
        mem_load <= load_req;
        mem_store <= store_req;
        mem_vaddr <= vaddr;
        hardware_int <= hw_int;
        @(negedge clk);
        check_value("flush_o", 32'(flush), 32'(exp_flush));
        if (exp_flush) begin
            check_value("target_pc_o", target_pc, exp_target);
        end
        @(posedge clk);
        clear_instr();
    endtask

    task automatic check_translation(input logic [31:0] vaddr, input logic [31:0] exp_paddr);
        instr_valid <= 1'b1;
        mem_load <= 1'b1;
        mem_vaddr <= vaddr;
        @(negedge clk);
        check_value("mem_paddr_o", mem_paddr, exp_paddr);
        check_value("flush_o", 32'(flush), 32'd0);
        @(posedge clk);
        clear_instr();
    endtask

    initial begin
        seed = 32'hee86;
        rst_n <= 1'b0;
        rd_addr <= 5'd0;
        we <= 1'b0;
        wr_addr <= 5'd0;
        wr_data <= 32'h0;
        tlbwi <= 1'b0;
        clear_instr();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        start_test("reset and masks");
        read_reg(cp0_pkg::STATUS, value);
        check_value("rd_data_o (Status)", value, 32'h0);
        read_reg(cp0_pkg::EBASE, value);
        check_value("rd_data_o (EBase)", value, 32'h8000_0000);
        for (int i = 0; i < 10; i++) begin
            wdata = $random(seed);
            write_reg(REG_LIST[i], wdata);
            read_reg(REG_LIST[i], value);
            check_value($sformatf("rd_data_o (reg %0d)", REG_LIST[i]), value,
                        masked_value(REG_LIST[i], wdata));
        end
        write_reg(cp0_pkg::STATUS, 32'h0);
        write_reg(cp0_pkg::CAUSE, 32'h0);
        write_reg(cp0_pkg::EBASE, 32'h0);
        write_reg(cp0_pkg::COMPARE, 32'h0);
        end_test();

        start_test("timer");
        write_reg(cp0_pkg::COUNT, 32'd0);
        write_reg(cp0_pkg::COMPARE, 32'd50);
        rd_addr <= cp0_pkg::COUNT;
        do begin
            @(negedge clk);
        end while (!timer_int);
        // Timer sets on the edge after the match, when Count has moved on by one.
        check_value("rd_data_o (Count)", rd_data, 32'd51);
        @(posedge clk);
        write_reg(cp0_pkg::COMPARE, 32'd0);
        @(negedge clk);
        check_value("timer_int_o", 32'(timer_int), 32'd0);
        @(posedge clk);
        end_test();

        start_test("exception capture");
        issue_instr(SYS_PC, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0, 6'h0, 1'b1, EXC_TARGET);
        read_reg(cp0_pkg::EPC, value);
        check_value("rd_data_o (EPC)", value, SYS_PC - 32'd4);
        read_reg(cp0_pkg::CAUSE, value);
        check_value("Cause.BD", 32'(value[31]), 32'd1);
        check_value("Cause.ExcCode", 32'(value[6:2]), 32'(cp0_pkg::SYS));
        read_reg(cp0_pkg::STATUS, value);
        check_value("Status.EXL", 32'(value[1]), 32'd1);
        end_test();

        start_test("interrupt");
        write_reg(cp0_pkg::STATUS, 32'h1);
        issue_instr(INT_PC, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 6'h01, 1'b1, EXC_TARGET);
        read_reg(cp0_pkg::CAUSE, value);
        check_value("Cause.ExcCode", 32'(value[6:2]), 32'(cp0_pkg::INT));
        // EXL is now set and holds off the same request.
        issue_instr(INT_PC + 32'd4, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 6'h01, 1'b0,
                    EXC_TARGET);
        end_test();

        start_test("eret");
        read_reg(cp0_pkg::EPC, value);
        check_value("rd_data_o (EPC)", value, INT_PC);
        issue_instr(32'h0040_0300, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 32'h0, 6'h0, 1'b1, INT_PC);
        read_reg(cp0_pkg::STATUS, value);
        check_value("Status.EXL", 32'(value[1]), 32'd0);
        end_test();

        start_test("tlb");
        write_reg(cp0_pkg::STATUS, 32'h0);
        write_reg(cp0_pkg::INDEX, 32'd3);
        write_reg(cp0_pkg::ENTRYHI, {VPN2, 13'b0});
        write_reg(cp0_pkg::ENTRYLO0, {2'b0, PFN_EVEN, 3'b0, 1'b1, 1'b1, 1'b0});
        write_reg(cp0_pkg::ENTRYLO1, {2'b0, PFN_ODD, 3'b0, 1'b0, 1'b1, 1'b0});
        tlbwi <= 1'b1;
        @(posedge clk);
        tlbwi <= 1'b0;
        check_translation({VPN2, 1'b0, 12'habc}, {PFN_EVEN[19:0], 12'habc});
        issue_instr(32'h0040_0400, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, MISS_VA, 6'h0, 1'b1,
                    EXC_TARGET);
        read_reg(cp0_pkg::BADVADDR, value);
        check_value("rd_data_o (BadVAddr)", value, MISS_VA);
        read_reg(cp0_pkg::CAUSE, value);
        check_value("Cause.ExcCode", 32'(value[6:2]), 32'(cp0_pkg::TLBL));
        // Odd page has D clear.
        issue_instr(32'h0040_0500, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, {VPN2, 1'b1, 12'h010},
                    6'h0, 1'b1, EXC_TARGET);
        read_reg(cp0_pkg::BADVADDR, value);
        check_value("rd_data_o (BadVAddr)", value, {VPN2, 1'b1, 12'h010});
        read_reg(cp0_pkg::CAUSE, value);
        check_value("Cause.ExcCode", 32'(value[6:2]), 32'(cp0_pkg::MOD));
        check_translation(32'h8001_2345, {3'b000, 29'h0001_2345});
        end_test();

        $display("Tests passed: %0d, tests failed: %0d, check errors: %0d, assertion errors: %0d",
                 tests_passed, tests_failed, errors, dut0.u_props.assert_errors);
        if (errors == 0 && dut0.u_props.assert_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cp0_tb -f all.f -o cp0_sim || exit 1
./obj_dir/cp0_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -qx "Finished with no errors" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
